/* verilog/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	// data and address width of the fetch path.
	localparam int WORD_BITS = 32;

	// cache controller states.
	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		STREAM,
		REFILL
	} icache_state_e;

	// wishbone read master states.
	typedef enum logic {
		BUS_IDLE,
		BUS_WAIT
	} wb_state_e;

endpackage

`default_nettype wire

/* verilog/fetch_pc_gen.sv */
`default_nettype none

module fetch_pc_gen (
	input wire i_clock,
	input wire i_rst,

	input wire i_redirect,
	input wire [fetch_pkg::WORD_BITS-1:0] i_redirect_pc,

	input wire i_word_taken,
	output logic [fetch_pkg::WORD_BITS-1:0] o_pc
);

	localparam logic [fetch_pkg::WORD_BITS-1:0] BOOT_PC = '0;

	logic redirect_pending;
	logic [fetch_pkg::WORD_BITS-1:0] redirect_target;

	// pending redirect, newest target wins.
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			redirect_pending <= 1'b0;
		end else if (i_word_taken) begin
			redirect_pending <= 1'b0; // consumed or applied right now.
		end else if (i_redirect) begin
			redirect_pending <= 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_redirect) begin
			redirect_target <= i_redirect_pc;
		end
	end

	// pc only moves once the word at pc was delivered.
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_pc <= BOOT_PC;
		end else if (i_word_taken) begin
			if (i_redirect) begin
				o_pc <= i_redirect_pc; // same-cycle redirect beats an older one.
			end else if (redirect_pending) begin
				o_pc <= redirect_target;
			end else begin
				o_pc <= o_pc + 4;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/cache_bram_clear.sv */
`default_nettype none

module cache_bram_clear #(
	parameter int INDEX_BITS = 8
) (
	input wire i_clock,
	input wire i_rst,

	input wire [INDEX_BITS-1:0] i_address,
	input wire i_write,
	input wire [2*fetch_pkg::WORD_BITS-1:0] i_wdata,
	output logic [2*fetch_pkg::WORD_BITS-1:0] o_rdata,

	output logic o_initialized
);

	localparam int DEPTH = 1 << INDEX_BITS;

	logic [2*fetch_pkg::WORD_BITS-1:0] mem [DEPTH];
	logic [INDEX_BITS-1:0] clear_index;

	// sweep counter, one entry per cycle after reset.
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			clear_index <= '0;
			o_initialized <= 1'b0;
		end else if (!o_initialized) begin
			clear_index <= clear_index + 1'b1;
			if (clear_index == INDEX_BITS'(DEPTH - 1)) begin
				o_initialized <= 1'b1;
			end
		end
	end

	// single port, zeros while sweeping.
	always_ff @(posedge i_clock) begin
		if (!o_initialized) begin
			mem[clear_index] <= '0;
		end else if (i_write) begin
			mem[i_address] <= i_wdata;
		end
	end

	// registered read, one cycle latency.
	always_ff @(posedge i_clock) begin
		o_rdata <= mem[i_address];
	end

endmodule

`default_nettype wire

/* verilog/icache_ctrl.sv */
`default_nettype none

module icache_ctrl #(
	parameter int INDEX_BITS = 8
) (
	input wire i_clock,
	input wire i_rst,

	// sequencer side.
	input wire [fetch_pkg::WORD_BITS-1:0] i_pc,
	output logic o_word_taken,

	// consumer side.
	input wire i_stall,
	output logic [fetch_pkg::WORD_BITS-1:0] o_instr,
	output logic [fetch_pkg::WORD_BITS-1:0] o_instr_pc,
	output logic o_instr_valid,

	// cache ram.
	output logic [INDEX_BITS-1:0] o_ram_address,
	output logic o_ram_write,
	output logic [2*fetch_pkg::WORD_BITS-1:0] o_ram_wdata,
	input wire [2*fetch_pkg::WORD_BITS-1:0] i_ram_rdata,
	input wire i_ram_initialized,

	// bus master.
	output logic o_bus_request,
	input wire i_bus_ready,
	input wire [fetch_pkg::WORD_BITS-1:0] i_bus_rdata
);

	localparam int W = fetch_pkg::WORD_BITS;

	fetch_pkg::icache_state_e state;
	fetch_pkg::icache_state_e next_state;

	logic [W-1:0] next_pc;
	logic [W-1:0] pc_tag;
	logic tag_hit;

	assign next_pc = i_pc + 4;
	assign pc_tag = {i_pc[W-1:2], 2'b01}; // marker bit keeps zeroed lines from hitting.
	assign tag_hit = i_ram_rdata[W-1:0] == pc_tag;

	assign o_instr_pc = i_pc;
	assign o_word_taken = o_instr_valid; // delivery and pc step are one event.

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= fetch_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		o_instr_valid = 1'b0;
		o_instr = i_ram_rdata[2*W-1:W];
		o_ram_address = i_pc[INDEX_BITS+1:2];
		o_ram_write = 1'b0;
		o_ram_wdata = {i_bus_rdata, pc_tag};
		o_bus_request = 1'b0;

		case (state)
			fetch_pkg::IDLE: begin
				if (!i_stall) begin
					if (i_ram_initialized) begin
						next_state = fetch_pkg::LOOKUP;
					end else begin
						// cache still sweeping, go straight to memory.
						o_bus_request = 1'b1;
						next_state = fetch_pkg::REFILL;
					end
				end
			end

			fetch_pkg::LOOKUP: begin
				if (!i_stall) begin
					if (tag_hit) begin
						o_instr_valid = 1'b1;
						o_ram_address = next_pc[INDEX_BITS+1:2];
						next_state = fetch_pkg::STREAM;
					end else begin
						o_bus_request = 1'b1;
						next_state = fetch_pkg::REFILL;
					end
				end
			end

			fetch_pkg::STREAM: begin
				if (!i_stall) begin
					if (tag_hit) begin
						o_instr_valid = 1'b1;
						o_ram_address = next_pc[INDEX_BITS+1:2]; // read ahead.
					end else begin
						// lookahead missed or pc was redirected, re-read at pc.
						next_state = fetch_pkg::LOOKUP;
					end
				end
			end

			fetch_pkg::REFILL: begin
				if (i_bus_ready) begin
					o_ram_write = 1'b1;
					o_instr = i_bus_rdata;
					o_instr_valid = !i_stall; // stalled words come back later as hits.
					next_state = fetch_pkg::IDLE;
				end else begin
					o_bus_request = 1'b1;
				end
			end

			default: begin
				next_state = fetch_pkg::IDLE;
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/wb_fetch_master.sv */
`default_nettype none

module wb_fetch_master (
	input wire i_clock,
	input wire i_rst,

	input wire i_bus_request,
	input wire [fetch_pkg::WORD_BITS-1:0] i_bus_address,
	output logic o_bus_ready,
	output logic [fetch_pkg::WORD_BITS-1:0] o_bus_rdata,

	output logic o_wb_cyc,
	output logic o_wb_stb,
	output logic o_wb_we,
	output logic [fetch_pkg::WORD_BITS-1:0] o_wb_adr,
	output logic [fetch_pkg::WORD_BITS/8-1:0] o_wb_sel,
	input wire [fetch_pkg::WORD_BITS-1:0] i_wb_dat,
	input wire i_wb_ack
);

	fetch_pkg::wb_state_e state;

	// classic single read, cyc and stb move together.
	assign o_wb_cyc = state == fetch_pkg::BUS_WAIT;
	assign o_wb_stb = state == fetch_pkg::BUS_WAIT;
	assign o_wb_we = 1'b0;
	assign o_wb_sel = '1; // full word reads only.

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= fetch_pkg::BUS_IDLE;
			o_bus_ready <= 1'b0;
		end else begin
			o_bus_ready <= 1'b0;
			case (state)
				fetch_pkg::BUS_IDLE: begin
					if (i_bus_request) begin
						state <= fetch_pkg::BUS_WAIT;
					end
				end
				fetch_pkg::BUS_WAIT: begin
					if (i_wb_ack) begin
						o_bus_ready <= 1'b1;
						state <= fetch_pkg::BUS_IDLE;
					end
				end
				default: state <= fetch_pkg::BUS_IDLE;
			endcase
		end
	end

	// address and data registers.
	always_ff @(posedge i_clock) begin
		if (state == fetch_pkg::BUS_IDLE && i_bus_request) begin
			o_wb_adr <= i_bus_address; // held until ack.
		end
		if (state == fetch_pkg::BUS_WAIT && i_wb_ack) begin
			o_bus_rdata <= i_wb_dat;
		end
	end

endmodule

`default_nettype wire

/* verilog/fetch_top.sv */
`default_nettype none

module fetch_top #(
	parameter int INDEX_BITS = 8
) (
	input wire i_clock,
	input wire i_rst,

	input wire i_redirect,
	input wire [fetch_pkg::WORD_BITS-1:0] i_redirect_pc,

	input wire i_stall,
	output logic [fetch_pkg::WORD_BITS-1:0] o_instr,
	output logic [fetch_pkg::WORD_BITS-1:0] o_instr_pc,
	output logic o_instr_valid,

	output logic o_wb_cyc,
	output logic o_wb_stb,
	output logic o_wb_we,
	output logic [fetch_pkg::WORD_BITS-1:0] o_wb_adr,
	output logic [fetch_pkg::WORD_BITS/8-1:0] o_wb_sel,
	input wire [fetch_pkg::WORD_BITS-1:0] i_wb_dat,
	input wire i_wb_ack
);

	logic [fetch_pkg::WORD_BITS-1:0] pc;
	logic word_taken;

	logic [INDEX_BITS-1:0] ram_address;
	logic ram_write;
	logic [2*fetch_pkg::WORD_BITS-1:0] ram_wdata;
	logic [2*fetch_pkg::WORD_BITS-1:0] ram_rdata;
	logic ram_initialized;

	logic bus_request;
	logic bus_ready;
	logic [fetch_pkg::WORD_BITS-1:0] bus_rdata;

	fetch_pc_gen u_pc_gen (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_redirect(i_redirect),
		.i_redirect_pc(i_redirect_pc),
		.i_word_taken(word_taken),
		.o_pc(pc)
	);

	icache_ctrl #(
		.INDEX_BITS(INDEX_BITS)
	) u_ctrl (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_pc(pc),
		.i_stall(i_stall),
		.o_word_taken(word_taken),
		.o_instr(o_instr),
		.o_instr_pc(o_instr_pc),
		.o_instr_valid(o_instr_valid),
		.o_ram_address(ram_address),
		.o_ram_write(ram_write),
		.o_ram_wdata(ram_wdata),
		.i_ram_rdata(ram_rdata),
		.i_ram_initialized(ram_initialized),
		.o_bus_request(bus_request),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata)
	);

	cache_bram_clear #(
		.INDEX_BITS(INDEX_BITS)
	) u_ram (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_address(ram_address),
		.i_write(ram_write),
		.i_wdata(ram_wdata),
		.o_rdata(ram_rdata),
		.o_initialized(ram_initialized)
	);

	// miss address is the current pc.
	wb_fetch_master u_bus (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_bus_request(bus_request),
		.i_bus_address(pc),
		.o_bus_ready(bus_ready),
		.o_bus_rdata(bus_rdata),
		.o_wb_cyc(o_wb_cyc),
		.o_wb_stb(o_wb_stb),
		.o_wb_we(o_wb_we),
		.o_wb_adr(o_wb_adr),
		.o_wb_sel(o_wb_sel),
		.i_wb_dat(i_wb_dat),
		.i_wb_ack(i_wb_ack)
	);

endmodule

`default_nettype wire

/* dv/fetch_properties.sv */
`default_nettype none

module fetch_properties (
	input wire i_clock,
	input wire i_rst,
	input wire o_wb_cyc,
	input wire o_wb_stb,
	input wire o_wb_we,
	input wire [fetch_pkg::WORD_BITS-1:0] o_wb_adr,
	input wire i_wb_ack,
	input wire o_instr_valid,
	input wire i_stall,
	input wire fetch_pkg::icache_state_e i_ctrl_state
);

	int failures = 0;

	stb_needs_cyc: assert property (@(posedge i_clock) disable iff (i_rst)
		o_wb_stb |-> o_wb_cyc)
		else begin
			$error("wishbone stb high without cyc.");
			failures++;
		end

	no_write: assert property (@(posedge i_clock) disable iff (i_rst)
		!o_wb_we)
		else begin
			$error("wishbone we raised on a read only master.");
			failures++;
		end

	// address held until the slave answers.
	adr_stable: assert property (@(posedge i_clock) disable iff (i_rst)
		o_wb_stb && !i_wb_ack |=> $stable(o_wb_adr))
		else begin
			$error("wishbone address changed before ack.");
			failures++;
		end

	valid_not_stalled: assert property (@(posedge i_clock) disable iff (i_rst)
		o_instr_valid |-> !i_stall)
		else begin
			$error("instruction delivered while stalled.");
			failures++;
		end

	// a bus cycle only runs while the controller waits on a refill.
	cyc_in_refill: assert property (@(posedge i_clock) disable iff (i_rst)
		o_wb_cyc |-> i_ctrl_state == fetch_pkg::REFILL)
		else begin
			$error("wishbone cycle open outside a refill.");
			failures++;
		end

endmodule

bind fetch_top fetch_properties u_props (
	.i_clock(i_clock),
	.i_rst(i_rst),
	.o_wb_cyc(o_wb_cyc),
	.o_wb_stb(o_wb_stb),
	.o_wb_we(o_wb_we),
	.o_wb_adr(o_wb_adr),
	.i_wb_ack(i_wb_ack),
	.o_instr_valid(o_instr_valid),
	.i_stall(i_stall),
	.i_ctrl_state(u_ctrl.state)
);

`default_nettype wire

/* dv/fetch_tb.sv */
`default_nettype none

module fetch_tb;

	localparam logic [31:0] MEM_KEY = 32'h5a5a_0000;
	localparam int STALL_NONE = 0;
	localparam int STALL_RANDOM = 1;
	localparam int ANY_COUNT = -1;
	localparam int ROW_TIMEOUT = 3000;

	typedef struct {
		string name;
		logic [31:0] target;
		int words;
		int stall_mode;
		int bus_cycles;
	} row_t;

	logic i_clock = 1'b0;
	logic i_rst;
	logic i_redirect;
	logic [31:0] i_redirect_pc;
	logic i_stall;
	logic [31:0] o_instr;
	logic [31:0] o_instr_pc;
	logic o_instr_valid;
	logic o_wb_cyc;
	logic o_wb_stb;
	logic o_wb_we;
	logic [31:0] o_wb_adr;
	logic [3:0] o_wb_sel;
	logic [31:0] i_wb_dat;
	logic i_wb_ack;

	logic [31:0] bus_seed = 32'h18e4_7adf;
	logic [31:0] stall_seed = 32'h18e4_7adf;
	logic [31:0] old_pc;
	logic in_cycle;
	string test_name;
	int ack_delay;
	int bus_count;
	int errors;
	int checks;
	row_t rows[7];

	fetch_top #(
		.INDEX_BITS(6)
	) DUT (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_redirect(i_redirect),
		.i_redirect_pc(i_redirect_pc),
		.i_stall(i_stall),
		.o_instr(o_instr),
		.o_instr_pc(o_instr_pc),
		.o_instr_valid(o_instr_valid),
		.o_wb_cyc(o_wb_cyc),
		.o_wb_stb(o_wb_stb),
		.o_wb_we(o_wb_we),
		.o_wb_adr(o_wb_adr),
		.o_wb_sel(o_wb_sel),
		.i_wb_dat(i_wb_dat),
		.i_wb_ack(i_wb_ack)
	);

	always #50 i_clock = ~i_clock;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// memory slave with 0 to 3 cycles of ack delay.
	always @(posedge i_clock) begin
		#1;
		if (i_wb_ack) begin
			i_wb_ack = 1'b0;
			in_cycle = 1'b0;
		end else if (o_wb_cyc && o_wb_stb) begin
			if (!in_cycle) begin
				in_cycle = 1'b1;
				bus_seed = lcg_next(bus_seed);
				ack_delay = bus_seed[17:16];
			end
			if (ack_delay == 0) begin
				i_wb_ack = 1'b1;
				i_wb_dat = o_wb_adr ^ MEM_KEY;
				check_value({test_name, " sel"}, 32'hf, o_wb_sel);
				check_value({test_name, " we"}, 32'h0, o_wb_we);
				if (o_wb_adr != old_pc) begin
					bus_count++; // old stream word not charged to the row.
				end
			end else begin
				ack_delay--;
			end
		end
	end

	always @(negedge i_clock) begin
		if (o_instr_valid && i_stall) begin
			errors++;
			$display("instruction delivered while stall was high at pc %h", o_instr_pc);
		end
	end

	task automatic step();
		@(posedge i_clock);
		#1;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("error %s: expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic run_row(input row_t row);
		int cycles;
		int got;
		logic old_seen;
		logic [31:0] expect_pc;
		cycles = 0;
		got = 0;
		old_seen = 1'b0;
		expect_pc = row.target;
		while (o_wb_cyc && cycles < 50) begin
			step();
			cycles++;
		end
		if (o_wb_cyc) begin
			errors++;
			$display("bus cycle did not finish before test %s", row.name);
		end
		test_name = row.name;
		bus_count = 0;
		i_redirect = 1'b1;
		i_redirect_pc = row.target;
		step();
		i_redirect = 1'b0;
		cycles = 0;
		while (got < row.words && cycles < ROW_TIMEOUT) begin
			if (row.stall_mode == STALL_RANDOM) begin
				stall_seed = lcg_next(stall_seed);
				i_stall = stall_seed[20];
			end else begin
				i_stall = 1'b0;
			end
			@(negedge i_clock);
			cycles++;
			if (o_instr_valid) begin
				check_value({row.name, " data"}, o_instr_pc ^ MEM_KEY, o_instr);
				if (got == 0 && !old_seen && o_instr_pc != row.target) begin
					old_seen = 1'b1; // one word from before the redirect.
					check_value({row.name, " old pc"}, old_pc, o_instr_pc);
				end else begin
					check_value({row.name, " pc"}, expect_pc, o_instr_pc);
					expect_pc = expect_pc + 4;
					got++;
				end
			end
			step();
		end
		i_stall = 1'b1;
		if (got < row.words) begin
			errors++;
			$display("test %s timed out after %0d of %0d words", row.name, got, row.words);
		end
		if (row.bus_cycles != ANY_COUNT) begin
			check_value({row.name, " bus cycles"}, row.bus_cycles, bus_count);
		end
		old_pc = expect_pc; // where the next row's redirect finds the pc.
	endtask

	initial begin
		int cycles;
		i_rst = 1'b1;
		i_redirect = 1'b0;
		i_redirect_pc = '0;
		i_stall = 1'b1;
		i_wb_dat = '0;
		i_wb_ack = 1'b0;
		in_cycle = 1'b0;
		ack_delay = 0;
		old_pc = '0;
		test_name = "reset";
		bus_count = 0;
		errors = 0;
		checks = 0;

		rows[0] = '{"cold_run", 32'h100, 16, STALL_NONE, 16};
		rows[1] = '{"warm_rerun", 32'h100, 16, STALL_NONE, 0};
		rows[2] = '{"random_stall", 32'h180, 16, STALL_RANDOM, ANY_COUNT};
		rows[3] = '{"redirect", 32'h104, 8, STALL_NONE, 0};
		rows[4] = '{"alias_miss", 32'h200, 1, STALL_NONE, 1};
		rows[5] = '{"evicted_line", 32'h100, 1, STALL_NONE, 1};
		rows[6] = '{"stalled_alias", 32'h200, 4, STALL_RANDOM, ANY_COUNT};

		repeat (5) @(posedge i_clock);
		#1;
		i_rst = 1'b0;
		// stall holds the fetch off through the ram sweep.
		cycles = 0;
		while (cycles < 80) begin
			@(negedge i_clock);
			checks++;
			if (o_wb_cyc || o_wb_stb || o_instr_valid) begin
				errors++;
				$display("bus or valid active after reset with no request");
			end
			cycles++;
		end

		for (int i = 0; i < 7; i++) begin
			run_row(rows[i]);
		end

		errors = errors + DUT.u_props.failures;
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* icache.f */
verilog/fetch_pkg.sv
verilog/fetch_pc_gen.sv
verilog/cache_bram_clear.sv
verilog/icache_ctrl.sv
verilog/wb_fetch_master.sv
verilog/fetch_top.sv
dv/fetch_properties.sv
dv/fetch_tb.sv
